//--- sram_test_pkg.sv
`default_nettype none

package sram_test_pkg;

  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 8;
  localparam int BANK_W     = 3;
  localparam int REG_ADDR_W = 2;

  typedef logic [DATA_W-1:0]     data_t;     // SRAM and Wishbone data word
  typedef logic [ADDR_W-1:0]     addr_t;     // Packet address, banks use the low bits
  typedef logic [BANK_W-1:0]     bank_t;     // Chip select code
  typedef logic [REG_ADDR_W-1:0] reg_addr_t; // Wishbone word address

  // Codes 2 to 7 have no macro behind them
  localparam bank_t BANK_SMALL = 3'd0;
  localparam bank_t BANK_LARGE = 3'd1;

  localparam int SMALL_ADDR_BITS = 6; // 64 words
  localparam int LARGE_ADDR_BITS = 8; // 256 words

  // Register map
  localparam reg_addr_t REG_CTRL  = 2'd0; // bit 0 web, bits 3:1 bank
  localparam reg_addr_t REG_ADDR  = 2'd1;
  localparam reg_addr_t REG_WDATA = 2'd2;
  localparam reg_addr_t REG_RDATA = 2'd3; // Read only

  // Cycles from start to done, start cycle included
  localparam int ACCESS_LATENCY = 3;

endpackage

`default_nettype wire

//--- sram_port_if.sv
`timescale 1ns/10ps
`default_nettype none

interface sram_port_if
  import sram_test_pkg::*;
();

  logic  csb;  // Chip select, active low
  logic  web;  // Write enable, active low
  addr_t addr; // Already trimmed to the bank depth
  data_t din;
  data_t dout;

  modport controller (
    output csb,
    output web,
    output addr,
    output din,
    input  dout
  );

  modport memory (
    input  csb,
    input  web,
    input  addr,
    input  din,
    output dout
  );

endinterface

`default_nettype wire

//--- sram_macro_model.sv
`timescale 1ns/10ps
`default_nettype none

module sram_macro_model
  import sram_test_pkg::*;
#(
  parameter int ADDR_BITS = 8
) (
  input  logic          clk,
  sram_port_if.memory   mem
);

  localparam int DEPTH = 1 << ADDR_BITS;

  data_t                mem_array [DEPTH];
  logic [ADDR_BITS-1:0] word_addr;

  // Upper packet bits are zero from the router
  assign word_addr = mem.addr[ADDR_BITS-1:0];

  // Single port with a registered read
  always_ff @(posedge clk) begin
    if (!mem.csb) begin
      if (!mem.web) begin
        mem_array[word_addr] <= mem.din;
      end else begin
        mem.dout <= mem_array[word_addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- wb_test_regs.sv
`timescale 1ns/10ps
`default_nettype none

module wb_test_regs
  import sram_test_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      wb_cyc,
  input  logic      wb_stb,
  input  logic      wb_we,
  input  reg_addr_t wb_adr,
  input  data_t     wb_wdata,
  output data_t     wb_rdata,
  output logic      wb_ack,
  output logic      start,
  output bank_t     bank,
  output logic      web,
  output addr_t     addr,
  output data_t     wdata,
  input  logic      done,
  input  data_t     rdata
);

  logic busy;
  logic access;
  logic stall;
  logic take;

  // ack is registered, so the cycle it is high still shows stb
  assign access = wb_cyc && wb_stb && !wb_ack;
  assign stall  = busy && (wb_adr == REG_CTRL || wb_adr == REG_RDATA);
  assign take   = access && !stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
      busy   <= 1'b0;
      bank   <= '0;
      web    <= 1'b1;
      addr   <= '0;
      wdata  <= '0;
    end else begin
      wb_ack <= take;
      start  <= 1'b0;
      if (done) begin
        busy <= 1'b0;
      end
      if (take && wb_we) begin
        case (wb_adr)
          REG_CTRL: begin
            web   <= wb_wdata[0];
            bank  <= wb_wdata[3:1];
            start <= 1'b1; // Fires the access
            busy  <= 1'b1;
          end
          REG_ADDR:  addr  <= wb_wdata[ADDR_W-1:0];
          REG_WDATA: wdata <= wb_wdata;
          default: ;     // RDATA writes are dropped
        endcase
      end
    end
  end

  // Read mux
  always_ff @(posedge clk) begin
    if (take && !wb_we) begin
      case (wb_adr)
        REG_CTRL:  wb_rdata <= data_t'({bank, web});
        REG_ADDR:  wb_rdata <= data_t'(addr);
        REG_WDATA: wb_rdata <= wdata;
        default:   wb_rdata <= rdata;
      endcase
    end
  end

  a_ack_in_cycle: assert property (
    @(posedge clk) disable iff (reset)
    wb_ack |-> (wb_cyc && wb_stb)
  ) else $error("wb_ack outside a bus cycle");

endmodule

`default_nettype wire

//--- sram_test_router.sv
`timescale 1ns/10ps
`default_nettype none

module sram_test_router
  import sram_test_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  bank_t                  bank,
  input  logic                   web,
  input  addr_t                  addr,
  input  data_t                  wdata,
  output logic                   done,
  output data_t                  rdata,
  sram_port_if.controller        small_port,
  sram_port_if.controller        large_port
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,   // csb low on the selected port
    ST_CAPTURE   // dout valid
  } state_t;

  state_t state;
  bank_t  bank_q;
  logic   web_q;
  addr_t  addr_q;
  data_t  wdata_q;

  // Packet copy held for the whole access
  always_ff @(posedge clk) begin
    if (start && state == ST_IDLE) begin
      bank_q  <= bank;
      web_q   <= web;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  // Address wraps to the bank depth
  assign small_port.addr = addr_t'(addr_q[SMALL_ADDR_BITS-1:0]);
  assign large_port.addr = addr_t'(addr_q[LARGE_ADDR_BITS-1:0]);
  assign small_port.din  = wdata_q;
  assign large_port.din  = wdata_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= ST_IDLE;
      done           <= 1'b0;
      rdata          <= '0;
      small_port.csb <= 1'b1;
      small_port.web <= 1'b1;
      large_port.csb <= 1'b1;
      large_port.web <= 1'b1;
    end else begin
      done           <= 1'b0;
      small_port.csb <= 1'b1; // Ports idle unless selected below
      small_port.web <= 1'b1;
      large_port.csb <= 1'b1;
      large_port.web <= 1'b1;
      case (state)
        ST_IDLE: begin
          if (start) begin
            small_port.csb <= (bank != BANK_SMALL);
            small_port.web <= (bank != BANK_SMALL) || web;
            large_port.csb <= (bank != BANK_LARGE);
            large_port.web <= (bank != BANK_LARGE) || web;
            state          <= ST_ACCESS;
          end
        end
        ST_ACCESS: state <= ST_CAPTURE;
        ST_CAPTURE: begin
          done  <= 1'b1;
          state <= ST_IDLE;
          if (web_q) begin // Writes keep the last read result
            case (bank_q)
              BANK_SMALL: rdata <= small_port.dout;
              BANK_LARGE: rdata <= large_port.dout;
              default:    rdata <= '0;
            endcase
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  a_one_bank: assert property (
    @(posedge clk) disable iff (reset)
    !(!small_port.csb && !large_port.csb)
  ) else $error("Both banks selected at once");

  a_latency: assert property (
    @(posedge clk) disable iff (reset)
    start |-> ##ACCESS_LATENCY done
  ) else $error("done missing after start");

endmodule

`default_nettype wire

//--- sram_test_top.sv
`timescale 1ns/10ps
`default_nettype none

module sram_test_top
  import sram_test_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      wb_cyc,
  input  logic      wb_stb,
  input  logic      wb_we,
  input  reg_addr_t wb_adr,
  input  data_t     wb_wdata,
  output data_t     wb_rdata,
  output logic      wb_ack
);

  logic  start;
  bank_t bank;
  logic  web;
  addr_t addr;
  data_t wdata;
  logic  done;
  data_t rdata;

  sram_port_if small_port ();
  sram_port_if large_port ();

  wb_test_regs u_regs (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .start    (start),
    .bank     (bank),
    .web      (web),
    .addr     (addr),
    .wdata    (wdata),
    .done     (done),
    .rdata    (rdata)
  );

  sram_test_router u_router (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .bank       (bank),
    .web        (web),
    .addr       (addr),
    .wdata      (wdata),
    .done       (done),
    .rdata      (rdata),
    .small_port (small_port.controller),
    .large_port (large_port.controller)
  );

  sram_macro_model #(.ADDR_BITS(SMALL_ADDR_BITS)) u_sram_small (
    .clk (clk),
    .mem (small_port.memory)
  );

  sram_macro_model #(.ADDR_BITS(LARGE_ADDR_BITS)) u_sram_large (
    .clk (clk),
    .mem (large_port.memory)
  );

endmodule

`default_nettype wire

//--- tb_sram_test.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sram_test
  import sram_test_pkg::*;
();

  localparam int ACK_TIMEOUT = 20; // Ack wait limit in cycles

  logic      clk;
  logic      reset;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  reg_addr_t wb_adr;
  data_t     wb_wdata;
  data_t     wb_rdata;
  logic      wb_ack;

  int          mismatch_count;
  int          timeout_count;
  int          other_count;
  logic [31:0] rand_state;

  sram_test_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // 0 to 3 idle cycles between bus operations
  task automatic idle_gap();
    logic [1:0] gap;
    rand_state = next_random(rand_state);
    gap = rand_state[17:16];
    repeat (gap) @(negedge clk);
  endtask

  task automatic write_register(input reg_addr_t adr, input data_t data);
    int cycles;
    cycles   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_wdata = data;
    @(negedge clk);
    while (!wb_ack && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    assert (wb_ack) else begin
      $display("Timeout at %0t: no ack for a write to register %0d", $time, adr);
      timeout_count++;
    end
    @(negedge clk); // Strobe stays up through the edge that samples ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_register(input reg_addr_t adr, output data_t data, output logic ok);
    int cycles;
    cycles = 0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    while (!wb_ack && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    ok   = wb_ack;
    data = wb_rdata; // Registered with ack
    assert (wb_ack) else begin
      $display("Timeout at %0t: no ack for a read of register %0d", $time, adr);
      timeout_count++;
    end
    @(negedge clk); // Strobe stays up through the edge that samples ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  initial begin
    int          fd;
    int          rc;
    string       line;
    logic [7:0]  op;
    logic [31:0] adr_val;
    logic [31:0] data_val;
    logic [31:0] exp_val;
    data_t       got;
    logic        ok;

    mismatch_count = 0;
    timeout_count  = 0;
    other_count    = 0;
    rand_state     = 32'hfe47;
    reset          = 1'b1;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_wdata       = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    fd = $fopen("sram_test_cases.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open sram_test_cases.txt");
      other_count++;
    end

    while (fd != 0 && !$feof(fd) && timeout_count == 0) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
        rc = $sscanf(line, "%c %h %h %h", op, adr_val, data_val, exp_val);
        idle_gap();
        if (rc != 4) begin
          $display("Malformed line in sram_test_cases.txt: %s", line);
          other_count++;
        end else if (op == "W") begin
          write_register(adr_val[1:0], data_val);
        end else if (op == "R") begin
          read_register(adr_val[1:0], got, ok);
          if (ok) begin
            assert (got === exp_val) else begin
              $display("Mismatch at %0t: register %0d read %h, expected %h",
                       $time, adr_val[1:0], got, exp_val);
              mismatch_count++;
            end
          end
        end else begin
          $display("Unknown operation in sram_test_cases.txt: %s", line);
          other_count++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    repeat (2) @(negedge clk);
    $display("Errors: %0d mismatches, %0d timeouts, %0d other",
             mismatch_count, timeout_count, other_count);
    if (mismatch_count + timeout_count + other_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sram_test_cases.txt
# Columns: op (W write, R read), register (0 ctrl, 1 addr, 2 wdata, 3 rdata),
# data in hex, expected read value in hex (ignored for W). Ctrl is {bank, web}
R 3 0 0
R 0 0 1
W 1 10 0
W 2 a5a51234 0
W 0 0 0
W 0 1 0
R 3 0 a5a51234
W 1 11 0
W 2 0badf00d 0
W 0 0 0
R 3 0 a5a51234
W 1 05 0
W 2 11110005 0
W 0 2 0
W 1 85 0
W 2 22220085 0
W 0 2 0
W 0 3 0
R 3 0 22220085
W 1 05 0
W 0 3 0
R 3 0 11110005
W 2 33330005 0
W 0 0 0
W 1 45 0
W 0 1 0
R 3 0 33330005
W 1 05 0
W 0 3 0
R 3 0 11110005
W 0 b 0
R 3 0 0
R 0 0 b
R 1 0 5
R 2 0 33330005

//--- src.f
sram_test_pkg.sv
sram_port_if.sv
sram_macro_model.sv
wb_test_regs.sv
sram_test_router.sv
sram_test_top.sv
tb_sram_test.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_sram_test -f src.f -o sim_tb \
  && out="$(./obj_dir/sim_tb)" \
  && echo "$out" \
  && echo "$out" | grep -qx "PASS: all tests" \
  || { echo "Simulation did not pass"; exit 1; }
